// File: green_screen_golden.txt
# mode bg fg x0 y0 x1 y1 stall exp_x exp_y has_com
# mode 0 camera, 1 mask, 2 camera; colors are RGB565 hex; box corners inclusive
0 07e0 f800 4 2 7 5 0 5 3 1
1 07e0 f800 4 2 7 5 0 5 3 1
1 2220 2200 0 0 15 7 0 7 3 1
0 2220 2200 10 1 13 6 1 11 3 1
1 07e0 07e0 0 0 0 0 0 0 0 0
2 07e0 001f 1 5 2 7 1 1 6 1
0 07e0 07e0 0 0 0 0 0 0 0 0
0 07e0 f800 15 7 15 7 0 15 7 1
1 2220 f800 2 0 9 3 1 5 1 1
0 07e0 f800 0 0 3 3 1 1 1 1

// File: green_screen_tracker.f
video_pkg.sv
pixel_pkg.sv
video_timing.sv
pixel_fetch.sv
chroma_key.sv
centroid_tracker.sv
overlay_mux.sv
green_screen_tracker.sv
green_screen_tracker_props.sv
tb_green_screen_tracker.sv

// File: tb_green_screen_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_green_screen_tracker;

  // small raster keeps a frame at 288 cycles
  localparam int H_ACTIVE     = 16;
  localparam int V_ACTIVE     = 8;
  localparam int H_TOTAL      = 24;
  localparam int V_TOTAL      = 12;
  localparam int KEY_MARGIN   = 32;
  localparam int NPIX         = H_ACTIVE * V_ACTIVE;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;
  // raster position to output pixel
  localparam int PIPE_DEPTH   = 3;
  localparam int MAX_FRAMES   = 32;
  localparam logic [31:0] SEED      = 32'h8b54_299b;
  localparam logic [15:0] FILL_WORD = 16'h2277;
  localparam logic [23:0] CROSS_RGB = 24'hff0000;

  logic                     clk_pixel;
  logic                     recent_reset;
  pixel_pkg::display_mode_e display_mode_i;
  logic                     pix_valid_i;
  pixel_pkg::rgb565_t       pix_data_i;
  logic                     pix_last_i;
  logic                     pix_ready_o;
  pixel_pkg::rgb888_t       pixel_o;
  video_pkg::hcount_t       hcount_o;
  video_pkg::vcount_t       vcount_o;
  logic                     de_o;
  video_pkg::hcount_t       com_x_o;
  video_pkg::vcount_t       com_y_o;
  logic                     com_valid_o;

  // one entry per golden line
  int          fr_mode[MAX_FRAMES];
  logic [15:0] fr_bg[MAX_FRAMES];
  logic [15:0] fr_fg[MAX_FRAMES];
  int          fr_x0[MAX_FRAMES];
  int          fr_y0[MAX_FRAMES];
  int          fr_x1[MAX_FRAMES];
  int          fr_y1[MAX_FRAMES];
  int          fr_stall[MAX_FRAMES];
  int          fr_ex[MAX_FRAMES];
  int          fr_ey[MAX_FRAMES];
  int          fr_has[MAX_FRAMES];
  int          num_frames;

  // expected picture before the crosshair, indexed by active position
  logic [23:0] exp_base[NPIX];
  // centroids still owed by the DUT
  int          exp_x_q[$];
  int          exp_y_q[$];
  // accepted words still on their way to the output
  int          due_cycle_q[$];
  int          due_pos_q[$];
  int          cycle_count = 0;
  int          hs_count;
  int          held_x;
  int          held_y;
  logic        pix_check_on;

  green_screen_tracker #(
    .H_ACTIVE   (H_ACTIVE),
    .V_ACTIVE   (V_ACTIVE),
    .H_TOTAL    (H_TOTAL),
    .V_TOTAL    (V_TOTAL),
    .KEY_MARGIN (KEY_MARGIN)
  ) u_green_screen_tracker (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .display_mode_i (display_mode_i),
    .pix_valid_i    (pix_valid_i),
    .pix_data_i     (pix_data_i),
    .pix_last_i     (pix_last_i),
    .pix_ready_o    (pix_ready_o),
    .pixel_o        (pixel_o),
    .hcount_o       (hcount_o),
    .vcount_o       (vcount_o),
    .de_o           (de_o),
    .com_x_o        (com_x_o),
    .com_y_o        (com_y_o),
    .com_valid_o    (com_valid_o)
  );

  initial begin
    clk_pixel = 1'b0;
    forever begin
      #20 clk_pixel = ~clk_pixel;
    end
  end

  // rising edges seen so far
  always @(posedge clk_pixel) begin
    cycle_count <= cycle_count + 1;
  end

  // ========================================
  // reference model and reporting
  // ========================================

  // 565 to 888 with zero low bits
  function automatic logic [23:0] expand_rgb565(input logic [15:0] w);
    return {w[15:11], 3'b000, w[10:5], 2'b00, w[4:0], 3'b000};
  endfunction

  // background only when green beats red and blue by more than the margin
  function automatic logic keyed_as_player(input logic [23:0] rgb);
    int r;
    int g;
    int b;
    r = rgb[23:16];
    g = rgb[15:8];
    b = rgb[7:0];
    return !((g > r + KEY_MARGIN) && (g > b + KEY_MARGIN));
  endfunction

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_failure(input string why);
    $display("%0t: %s", $time, why);
    stop_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, expected);
      stop_run();
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    int          m, x0, y0, x1, y1, st, ex, ey, eh;
    logic [15:0] bg;
    logic [15:0] fg;
    string       line;
    num_frames = 0;
    fd = $fopen("green_screen_golden.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open green_screen_golden.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // skip comments and blank lines
      if (line.len() > 1 && line.getc(0) != "#" && num_frames < MAX_FRAMES) begin
        n = $sscanf(line, "%d %h %h %d %d %d %d %d %d %d %d",
                    m, bg, fg, x0, y0, x1, y1, st, ex, ey, eh);
        if (n == 11) begin
          fr_mode[num_frames]  = m;
          fr_bg[num_frames]    = bg;
          fr_fg[num_frames]    = fg;
          fr_x0[num_frames]    = x0;
          fr_y0[num_frames]    = y0;
          fr_x1[num_frames]    = x1;
          fr_y1[num_frames]    = y1;
          fr_stall[num_frames] = st;
          fr_ex[num_frames]    = ex;
          fr_ey[num_frames]    = ey;
          fr_has[num_frames]   = eh;
          num_frames++;
        end
      end
    end
    $fclose(fd);
    if (num_frames == 0) begin
      report_failure("golden file holds no frames");
    end
  endtask

  // ========================================
  // stream source, one word per active position
  // ========================================
  task automatic run_frame(input int f);
    int          k;
    int          x;
    int          y;
    int          waited;
    int          stalls;
    int          hs_start;
    int          count;
    int          sum_x;
    int          sum_y;
    logic        in_box;
    logic        player;
    logic [15:0] word;
    logic [23:0] rgb;
    stalls = 0;
    count  = 0;
    sum_x  = 0;
    sum_y  = 0;
    // let the previous frame drain out of the pipeline before the mode flips
    if (f > 0) begin
      repeat (PIPE_DEPTH) @(posedge clk_pixel);
    end
    hs_start = hs_count;
    display_mode_i <= pixel_pkg::display_mode_e'(2'(fr_mode[f]));
    for (k = 0; k < NPIX; k++) begin
      x = k % H_ACTIVE;
      y = k / H_ACTIVE;
      in_box = (x >= fr_x0[f]) && (x <= fr_x1[f]) && (y >= fr_y0[f]) && (y <= fr_y1[f]);
      word = in_box ? fr_fg[f] : fr_bg[f];
      // stalls stay inside the box and never hit the last word
      if (fr_stall[f] != 0 && in_box && k != NPIX - 1 && ($urandom % 4) == 0) begin
        pix_valid_i <= 1'b0;
        pix_data_i  <= '0;
        pix_last_i  <= 1'b0;
        word = FILL_WORD;
        stalls++;
      end else begin
        pix_valid_i <= 1'b1;
        pix_data_i  <= word;
        pix_last_i  <= (k == NPIX - 1);
      end
      // ready marks the raster reaching the next active position
      waited = 0;
      @(negedge clk_pixel);
      while (!pix_ready_o) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          report_failure("timeout waiting for pix_ready_o");
        end
        @(negedge clk_pixel);
      end
      rgb    = expand_rgb565(word);
      player = keyed_as_player(rgb);
      if (fr_mode[f] == 1) begin
        exp_base[k] = player ? 24'hffffff : 24'h000000;
      end else begin
        exp_base[k] = rgb;
      end
      // the word moves on the next edge and leaves the last stage PIPE_DEPTH edges on
      due_cycle_q.push_back(cycle_count + PIPE_DEPTH);
      due_pos_q.push_back(k);
      if (player) begin
        sum_x += x;
        sum_y += y;
        count++;
      end
      @(posedge clk_pixel);
    end
    pix_valid_i <= 1'b0;
    pix_last_i  <= 1'b0;
    check_value("transfers", hs_count - hs_start, NPIX - stalls);
    // the previous frame's centroid lands well inside this frame
    if (exp_x_q.size() != 0) begin
      report_failure("no com_valid_o pulse for the previous frame");
    end
    check_value("golden com flag", fr_has[f], count > 0);
    if (count > 0) begin
      check_value("golden com_x", fr_ex[f], sum_x / count);
      check_value("golden com_y", fr_ey[f], sum_y / count);
      exp_x_q.push_back(fr_ex[f]);
      exp_y_q.push_back(fr_ey[f]);
    end
  endtask

  // ========================================
  // output monitor, samples mid-cycle
  // ========================================
  initial begin : output_monitor
    int          p;
    int          x;
    int          y;
    logic [23:0] expected;
    @(posedge clk_pixel);
    forever begin
      @(negedge clk_pixel);
      if (u_green_screen_tracker.u_green_screen_tracker_props.fail_count != 0) begin
        report_failure("an assertion in green_screen_tracker_props failed");
      end
      if (recent_reset) begin
        check_value("pix_ready_o", pix_ready_o, 0);
        check_value("de_o", de_o, 0);
        check_value("com_valid_o", com_valid_o, 0);
      end else begin
        // handshakes seen on the stream, the transfer happens on the next edge
        if (pix_valid_i && pix_ready_o) begin
          hs_count++;
        end
        if (pix_check_on) begin
          if (due_cycle_q.size() != 0 && due_cycle_q[0] == cycle_count) begin
            void'(due_cycle_q.pop_front());
            p = due_pos_q.pop_front();
            x = p % H_ACTIVE;
            y = p / H_ACTIVE;
            check_value("de_o", de_o, 1);
            check_value("hcount_o", hcount_o, x);
            check_value("vcount_o", vcount_o, y);
            // pixel first, it was built with the centroid held before this edge
            if (x == held_x || y == held_y) begin
              expected = CROSS_RGB;
            end else begin
              expected = exp_base[p];
            end
            check_value("pixel_o", pixel_o, expected);
          end else begin
            check_value("de_o", de_o, 0);
          end
        end
        if (com_valid_o) begin
          if (exp_x_q.size() == 0) begin
            report_failure("com_valid_o pulsed after a frame without player pixels");
          end else begin
            held_x = exp_x_q.pop_front();
            held_y = exp_y_q.pop_front();
          end
        end
        check_value("com_x_o", com_x_o, held_x);
        check_value("com_y_o", com_y_o, held_y);
      end
    end
  end

  initial begin : main_sequence
    int f;
    int waited;
    void'($urandom(SEED));
    recent_reset   <= 1'b1;
    display_mode_i <= pixel_pkg::DISP_CAMERA;
    pix_valid_i    <= 1'b0;
    pix_data_i     <= '0;
    pix_last_i     <= 1'b0;
    held_x         = 0;
    held_y         = 0;
    hs_count       = 0;
    pix_check_on   = 1'b1;
    load_golden();
    repeat (8) @(posedge clk_pixel);
    recent_reset <= 1'b0;
    for (f = 0; f < num_frames; f++) begin
      run_frame(f);
    end
    // last frame leaves the pipeline, later frames are unfed fill
    repeat (PIPE_DEPTH) @(posedge clk_pixel);
    pix_check_on = 1'b0;
    waited = 0;
    while (exp_x_q.size() != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure("timeout waiting for the final com_valid_o pulse");
      end
      @(negedge clk_pixel);
    end
    if (u_green_screen_tracker.u_green_screen_tracker_props.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      report_failure("an assertion in green_screen_tracker_props failed");
    end
  end

endmodule

`default_nettype wire

// File: green_screen_tracker_props.sv
`timescale 1ns/1ps
`default_nettype none

module green_screen_tracker_props (
  input wire        clk_pixel,
  input wire        recent_reset,
  input wire        pix_ready_i,
  input wire        de_i,
  input wire [23:0] pixel_i,
  input wire        com_valid_i
);

  // failures seen so far, one count per property
  int ready_fails = 0;
  int pulse_fails = 0;
  int blank_fails = 0;
  int fail_count;

  assign fail_count = ready_fails + pulse_fails + blank_fails;

  // ========================================
  // stream intake
  // ========================================

  // the accepted position shows up as display enable three stages on
  a_ready_reaches_de : assert property (
    @(posedge clk_pixel) disable iff (recent_reset) pix_ready_i |-> ##3 de_i
  ) else begin
    ready_fails++;
    $error("accepted position never reached de_o");
  end

  // ========================================
  // pipeline outputs
  // ========================================

  // centroid done is a single-cycle strobe
  a_com_single_pulse : assert property (
    @(posedge clk_pixel) disable iff (recent_reset) com_valid_i |=> !com_valid_i
  ) else begin
    pulse_fails++;
    $error("com_valid_o high on two cycles in a row");
  end

  // blanking is always black
  a_black_in_blank : assert property (
    @(posedge clk_pixel) disable iff (recent_reset) !de_i |-> (pixel_i == 24'h000000)
  ) else begin
    blank_fails++;
    $error("pixel_o not black while de_o is low");
  end

endmodule

bind green_screen_tracker green_screen_tracker_props u_green_screen_tracker_props (
  .clk_pixel    (clk_pixel),
  .recent_reset (recent_reset),
  .pix_ready_i  (pix_ready_o),
  .de_i         (de_o),
  .pixel_i      (pixel_o),
  .com_valid_i  (com_valid_o)
);

`default_nettype wire

// File: green_screen_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module green_screen_tracker #(
  parameter int H_ACTIVE   = 1280,
  parameter int V_ACTIVE   = 720,
  parameter int H_TOTAL    = 1650,
  parameter int V_TOTAL    = 750,
  parameter int KEY_MARGIN = 32
) (
  input  wire                      clk_pixel,
  input  wire                      recent_reset,
  input  pixel_pkg::display_mode_e display_mode_i,
  input  wire                      pix_valid_i,
  input  pixel_pkg::rgb565_t       pix_data_i,
  input  wire                      pix_last_i,
  output logic                     pix_ready_o,
  output pixel_pkg::rgb888_t       pixel_o,
  output video_pkg::hcount_t       hcount_o,
  output video_pkg::vcount_t       vcount_o,
  output logic                     de_o,
  output video_pkg::hcount_t       com_x_o,
  output video_pkg::vcount_t       com_y_o,
  output logic                     com_valid_o
);

  // raster, combinational from the counters
  video_pkg::hcount_t vt_hcount;
  video_pkg::vcount_t vt_vcount;
  logic               vt_active;
  logic               vt_frame_start;

  // after intake, one cycle
  video_pkg::hcount_t pf_hcount;
  video_pkg::vcount_t pf_vcount;
  logic               pf_active;
  logic               pf_frame_start;
  pixel_pkg::rgb888_t pf_pixel;

  // after keying, two cycles
  video_pkg::hcount_t ck_hcount;
  video_pkg::vcount_t ck_vcount;
  logic               ck_active;
  logic               ck_frame_start;
  pixel_pkg::rgb888_t ck_pixel;
  logic               ck_is_player;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_TOTAL  (V_TOTAL)
  ) u_video_timing (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .hcount_o      (vt_hcount),
    .vcount_o      (vt_vcount),
    .active_o      (vt_active),
    .frame_start_o (vt_frame_start)
  );

  pixel_fetch #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) u_pixel_fetch (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .hcount_i      (vt_hcount),
    .vcount_i      (vt_vcount),
    .active_i      (vt_active),
    .frame_start_i (vt_frame_start),
    .pix_valid_i   (pix_valid_i),
    .pix_data_i    (pix_data_i),
    .pix_last_i    (pix_last_i),
    .pix_ready_o   (pix_ready_o),
    .hcount_o      (pf_hcount),
    .vcount_o      (pf_vcount),
    .active_o      (pf_active),
    .frame_start_o (pf_frame_start),
    .pixel_o       (pf_pixel)
  );

  chroma_key #(
    .KEY_MARGIN (KEY_MARGIN)
  ) u_chroma_key (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .hcount_i      (pf_hcount),
    .vcount_i      (pf_vcount),
    .active_i      (pf_active),
    .frame_start_i (pf_frame_start),
    .pixel_i       (pf_pixel),
    .hcount_o      (ck_hcount),
    .vcount_o      (ck_vcount),
    .active_o      (ck_active),
    .frame_start_o (ck_frame_start),
    .pixel_o       (ck_pixel),
    .is_player_o   (ck_is_player)
  );

  // centroid runs beside the display path, its result lands on a later frame
  centroid_tracker u_centroid_tracker (
    .clk_pixel     (clk_pixel),
    .recent_reset  (recent_reset),
    .hcount_i      (ck_hcount),
    .vcount_i      (ck_vcount),
    .frame_start_i (ck_frame_start),
    .is_player_i   (ck_is_player),
    .com_x_o       (com_x_o),
    .com_y_o       (com_y_o),
    .com_valid_o   (com_valid_o)
  );

  overlay_mux u_overlay_mux (
    .clk_pixel      (clk_pixel),
    .recent_reset   (recent_reset),
    .display_mode_i (display_mode_i),
    .hcount_i       (ck_hcount),
    .vcount_i       (ck_vcount),
    .active_i       (ck_active),
    .pixel_i        (ck_pixel),
    .is_player_i    (ck_is_player),
    .com_x_i        (com_x_o),
    .com_y_i        (com_y_o),
    .pixel_o        (pixel_o),
    .hcount_o       (hcount_o),
    .vcount_o       (vcount_o),
    .de_o           (de_o)
  );

endmodule

`default_nettype wire

// File: overlay_mux.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_mux (
  input  wire                      clk_pixel,
  input  wire                      recent_reset,
  input  pixel_pkg::display_mode_e display_mode_i,
  input  video_pkg::hcount_t       hcount_i,
  input  video_pkg::vcount_t       vcount_i,
  input  wire                      active_i,
  input  pixel_pkg::rgb888_t       pixel_i,
  input  wire                      is_player_i,
  input  video_pkg::hcount_t       com_x_i,
  input  video_pkg::vcount_t       com_y_i,
  output pixel_pkg::rgb888_t       pixel_o,
  output video_pkg::hcount_t       hcount_o,
  output video_pkg::vcount_t       vcount_o,
  output logic                     de_o
);

  pixel_pkg::rgb888_t base_pixel;
  pixel_pkg::rgb888_t next_pixel;
  logic               on_crosshair;

  // background layer, unknown modes show the camera
  always_comb begin
    if (display_mode_i == pixel_pkg::DISP_MASK) begin
      base_pixel = is_player_i ? pixel_pkg::PIXEL_WHITE : pixel_pkg::PIXEL_BLACK;
    end else begin
      base_pixel = pixel_i;
    end
  end

  // full-width and full-height lines through the centroid
  assign on_crosshair = (hcount_i == com_x_i) || (vcount_i == com_y_i);

  always_comb begin
    if (!active_i) begin
      next_pixel = pixel_pkg::PIXEL_BLACK;
    end else if (on_crosshair) begin
      next_pixel = pixel_pkg::CROSSHAIR_COLOR;
    end else begin
      next_pixel = base_pixel;
    end
  end

  // ========================================
  // output register
  // ========================================
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      de_o    <= 1'b0;
      pixel_o <= pixel_pkg::PIXEL_BLACK;
    end else begin
      de_o    <= active_i;
      pixel_o <= next_pixel;
    end
  end

  always_ff @(posedge clk_pixel) begin
    hcount_o <= hcount_i;
    vcount_o <= vcount_i;
  end

endmodule

`default_nettype wire

// File: centroid_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_tracker (
  input  wire                clk_pixel,
  input  wire                recent_reset,
  input  video_pkg::hcount_t hcount_i,
  input  video_pkg::vcount_t vcount_i,
  input  wire                frame_start_i,
  input  wire                is_player_i,
  output video_pkg::hcount_t com_x_o,
  output video_pkg::vcount_t com_y_o,
  output logic               com_valid_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DIV_X,
    ST_DIV_Y
  } state_e;

  state_e                 state_q;
  logic [4:0]             bit_q;
  // running sums for the frame being drawn
  video_pkg::sum_t        acc_x_q;
  video_pkg::sum_t        acc_y_q;
  video_pkg::pix_count_t  acc_n_q;
  // divider datapath
  video_pkg::sum_t        quo_q;
  video_pkg::sum_t        rem_q;
  video_pkg::sum_t        sum_y_q;
  video_pkg::pix_count_t  div_q;
  video_pkg::hcount_t     quot_x_q;
  video_pkg::sum_t        rem_shift;
  video_pkg::sum_t        divisor;
  video_pkg::sum_t        rem_next;
  video_pkg::sum_t        quo_next;
  logic                   take;
  logic                   start_div;
  logic                   last_bit;

  // a frame with no player pixels leaves the held centroid alone
  assign start_div = (state_q == ST_IDLE) && frame_start_i && (acc_n_q != '0);
  assign last_bit  = (bit_q == 5'd31);

  // ========================================
  // restoring divider, one quotient bit per cycle
  // ========================================
  // remainder stays below the 21-bit divisor so 32 bits never overflow
  assign divisor   = video_pkg::sum_t'(div_q);
  assign rem_shift = {rem_q[30:0], quo_q[31]};
  assign take      = (rem_shift >= divisor);
  assign rem_next  = take ? rem_shift - divisor : rem_shift;
  assign quo_next  = {quo_q[30:0], take};

  // control and accumulators
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      state_q     <= ST_IDLE;
      bit_q       <= '0;
      acc_x_q     <= '0;
      acc_y_q     <= '0;
      acc_n_q     <= '0;
      com_x_o     <= '0;
      com_y_o     <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= 1'b0;
      // pixel at 0,0 already belongs to the new frame
      if (frame_start_i) begin
        acc_x_q <= is_player_i ? video_pkg::sum_t'(hcount_i) : '0;
        acc_y_q <= is_player_i ? video_pkg::sum_t'(vcount_i) : '0;
        acc_n_q <= is_player_i ? 21'd1 : '0;
      end else if (is_player_i) begin
        acc_x_q <= acc_x_q + video_pkg::sum_t'(hcount_i);
        acc_y_q <= acc_y_q + video_pkg::sum_t'(vcount_i);
        acc_n_q <= acc_n_q + 21'd1;
      end
      case (state_q)
        ST_IDLE: begin
          bit_q <= '0;
          if (start_div) begin
            state_q <= ST_DIV_X;
          end
        end
        ST_DIV_X: begin
          bit_q <= bit_q + 5'd1;
          if (last_bit) begin
            state_q <= ST_DIV_Y;
          end
        end
        ST_DIV_Y: begin
          bit_q <= bit_q + 5'd1;
          if (last_bit) begin
            // x and y change together so the crosshair never splits
            com_x_o     <= quot_x_q;
            com_y_o     <= quo_next[9:0];
            com_valid_o <= 1'b1;
            state_q     <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // datapath follows the state, no reset needed
  always_ff @(posedge clk_pixel) begin
    if (start_div) begin
      quo_q   <= acc_x_q;
      rem_q   <= '0;
      sum_y_q <= acc_y_q;
      div_q   <= acc_n_q;
    end else if (state_q == ST_DIV_X && last_bit) begin
      quot_x_q <= quo_next[10:0];
      quo_q    <= sum_y_q;
      rem_q    <= '0;
    end else if (state_q != ST_IDLE) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
    end
  end

endmodule

`default_nettype wire

// File: chroma_key.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_key #(
  parameter int KEY_MARGIN = 32
) (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  video_pkg::hcount_t  hcount_i,
  input  video_pkg::vcount_t  vcount_i,
  input  wire                 active_i,
  input  wire                 frame_start_i,
  input  pixel_pkg::rgb888_t  pixel_i,
  output video_pkg::hcount_t  hcount_o,
  output video_pkg::vcount_t  vcount_o,
  output logic                active_o,
  output logic                frame_start_o,
  output pixel_pkg::rgb888_t  pixel_o,
  output logic                is_player_o
);

  // one guard bit above channel plus margin
  logic [9:0] red_ext;
  logic [9:0] green_ext;
  logic [9:0] blue_ext;
  logic       background;

  assign red_ext   = {2'b00, pixel_i[23:16]};
  assign green_ext = {2'b00, pixel_i[15:8]};
  assign blue_ext  = {2'b00, pixel_i[7:0]};

  // green screen when green dominates both other channels by the margin
  assign background = (green_ext > red_ext + 10'(KEY_MARGIN))
                   && (green_ext > blue_ext + 10'(KEY_MARGIN));

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      active_o      <= 1'b0;
      frame_start_o <= 1'b0;
      is_player_o   <= 1'b0;
    end else begin
      active_o      <= active_i;
      frame_start_o <= frame_start_i;
      // blanking never counts as player
      is_player_o   <= active_i && !background;
    end
  end

  always_ff @(posedge clk_pixel) begin
    hcount_o <= hcount_i;
    vcount_o <= vcount_i;
    pixel_o  <= pixel_i;
  end

endmodule

`default_nettype wire

// File: pixel_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_fetch #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire                 clk_pixel,
  input  wire                 recent_reset,
  input  video_pkg::hcount_t  hcount_i,
  input  video_pkg::vcount_t  vcount_i,
  input  wire                 active_i,
  input  wire                 frame_start_i,
  input  wire                 pix_valid_i,
  input  pixel_pkg::rgb565_t  pix_data_i,
  input  wire                 pix_last_i,
  output logic                pix_ready_o,
  output video_pkg::hcount_t  hcount_o,
  output video_pkg::vcount_t  vcount_o,
  output logic                active_o,
  output logic                frame_start_o,
  output pixel_pkg::rgb888_t  pixel_o
);

  logic               final_pos;
  logic               xfer;
  pixel_pkg::rgb565_t word;
  pixel_pkg::chan_t   red;
  pixel_pkg::chan_t   green;
  pixel_pkg::chan_t   blue;

  // last active pixel of the frame
  assign final_pos = (hcount_i == video_pkg::hcount_t'(H_ACTIVE - 1))
                  && (vcount_i == video_pkg::vcount_t'(V_ACTIVE - 1));

  // a word marked last is held back until the raster reaches the final position,
  // so an early frame end parks the stream until the next frame
  assign pix_ready_o = active_i && !(pix_last_i && !final_pos);
  assign xfer        = pix_valid_i && pix_ready_o;

  // no transfer means fill color, the raster never waits
  assign word = xfer ? pix_data_i : pixel_pkg::FILL_COLOR;

  // 565 to 888, low bits zero
  assign red   = {word[15:11], 3'b000};
  assign green = {word[10:5], 2'b00};
  assign blue  = {word[4:0], 3'b000};

  // ========================================
  // stage register
  // ========================================
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      active_o      <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      active_o      <= active_i;
      frame_start_o <= frame_start_i;
    end
  end

  always_ff @(posedge clk_pixel) begin
    hcount_o <= hcount_i;
    vcount_o <= vcount_i;
    pixel_o  <= {red, green, blue};
  end

endmodule

`default_nettype wire

// File: video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720,
  parameter int H_TOTAL  = 1650,
  parameter int V_TOTAL  = 750
) (
  input  wire                clk_pixel,
  input  wire                recent_reset,
  output video_pkg::hcount_t hcount_o,
  output video_pkg::vcount_t vcount_o,
  output logic               active_o,
  output logic               frame_start_o
);

  video_pkg::hcount_t hcount_q;
  video_pkg::vcount_t vcount_q;
  // low until the first cycle after reset, keeps ready and draw off while in reset
  logic running_q;
  logic line_end;
  logic frame_end;

  assign line_end  = (hcount_q == video_pkg::hcount_t'(H_TOTAL - 1));
  assign frame_end = (vcount_q == video_pkg::vcount_t'(V_TOTAL - 1));

  // pixel and line counters, wrap at the totals
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      hcount_q  <= '0;
      vcount_q  <= '0;
      running_q <= 1'b0;
    end else if (!running_q) begin
      // hold at 0,0 for one cycle so the first frame start is seen
      running_q <= 1'b1;
    end else if (line_end) begin
      hcount_q <= '0;
      vcount_q <= frame_end ? '0 : vcount_q + 10'd1;
    end else begin
      hcount_q <= hcount_q + 11'd1;
    end
  end

  // outputs decode the counters directly
  assign hcount_o      = hcount_q;
  assign vcount_o      = vcount_q;
  assign active_o      = running_q
                      && (hcount_q < video_pkg::hcount_t'(H_ACTIVE))
                      && (vcount_q < video_pkg::vcount_t'(V_ACTIVE));
  assign frame_start_o = running_q && (hcount_q == '0) && (vcount_q == '0);

endmodule

`default_nettype wire

// File: pixel_pkg.sv
`default_nettype none

package pixel_pkg;

  // frame buffer word, r in [15:11], g in [10:5], b in [4:0]
  typedef logic [15:0] rgb565_t;

  // one expanded color channel
  typedef logic [7:0] chan_t;

  // output pixel, red high byte, then green, then blue
  typedef logic [23:0] rgb888_t;

  // what the output shows behind the crosshair
  // codes 2 and 3 fall back to the camera image
  typedef enum logic [1:0] {
    DISP_CAMERA = 2'd0,
    DISP_MASK   = 2'd1
  } display_mode_e;

  // shown wherever the stream has no word for an active position
  localparam rgb565_t FILL_COLOR = 16'h2277;

  // crosshair through the held centroid
  localparam rgb888_t CROSSHAIR_COLOR = 24'hFF0000;

  // mask colors
  localparam rgb888_t PIXEL_WHITE = 24'hFFFFFF;
  localparam rgb888_t PIXEL_BLACK = 24'h000000;

endpackage

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

package video_pkg;

  // ========================================
  // raster position types
  // ========================================

  // column inside a line, covers totals up to 2047
  typedef logic [10:0] hcount_t;

  // line inside a frame, covers totals up to 1023
  typedef logic [9:0] vcount_t;

  // ========================================
  // per-frame accumulation types
  // ========================================

  // sum of player positions over one frame
  // 1280 x 720 pixels times a max column of 1279 still fits
  typedef logic [31:0] sum_t;

  // number of player pixels in one frame
  typedef logic [20:0] pix_count_t;

endpackage

`default_nettype wire
